// File: Bender.yml
package:
  name: fetch_frontend

sources:
  - logic/fetch_pkg.sv
  - logic/fetch_rsp_if.sv
  - logic/fetch_ctrl.sv
  - logic/branch_scan.sv
  - logic/branch_history_table.sv
  - logic/fetch_queue.sv
  - logic/fetch_frontend.sv
  - target: test
    files:
      - verification/tb_fetch_frontend.sv

// File: logic/branch_history_table.sv
// branch_history_table: 2-bit counters with valid bits, direction lookup and resolve update
`timescale 1ns/1ps

module branch_history_table
  import fetch_pkg::*;
#(
  parameter int unsigned BhtEntries = 16
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  fetch_rsp_if.bht    rsp,
  // resolved conditional branch from execute
  input  logic        upd_valid_i,
  input  xlen_t       upd_pc_i,
  input  logic        upd_taken_i
);

  localparam int unsigned IdxW = $clog2(BhtEntries);

  counter_t                cnt_q [BhtEntries];
  logic [BhtEntries-1:0]   valid_q;
  logic [IdxW-1:0]         rd_idx;
  logic [IdxW-1:0]         wr_idx;
  counter_t                cnt_old;
  counter_t                cnt_new;

  // word aligned pc, bits 1:0 skipped
  assign rd_idx = rsp.pc[IdxW+1:2];
  assign wr_idx = upd_pc_i[IdxW+1:2];

  // untrained entry falls back to backward taken
  assign rsp.pred_taken = valid_q[rd_idx] ? cnt_q[rd_idx][1] : rsp.imm[XLEN-1];

  // ----------------------------------------------------------------------
  // counter update
  // ----------------------------------------------------------------------
  assign cnt_old = cnt_q[wr_idx];

  always_comb begin
    cnt_new = cnt_old;
    if (!valid_q[wr_idx]) begin
      // first resolve starts weak in its own direction
      cnt_new = upd_taken_i ? CNT_WEAK_T : CNT_WEAK_NT;
    end else if (upd_taken_i) begin
      if (cnt_old != CNT_STRONG_T) begin
        cnt_new = cnt_old + 2'd1;
      end
    end else begin
      if (cnt_old != CNT_STRONG_NT) begin
        cnt_new = cnt_old - 2'd1;
      end
    end
  end

  // read above sees the old value on a same-index write
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
      for (int i = 0; i < BhtEntries; i++) begin
        cnt_q[i] <= CNT_STRONG_NT;
      end
    end else if (upd_valid_i) begin
      valid_q[wr_idx] <= 1'b1;
      cnt_q[wr_idx]   <= cnt_new;
    end
  end

endmodule

// File: logic/branch_scan.sv
// branch_scan: opcode match for branch and jal, b-type and j-type immediate extraction
`timescale 1ns/1ps

module branch_scan
  import fetch_pkg::*;
(
  fetch_rsp_if.scan rsp
);

  logic [6:0] opcode;
  logic       opc_branch;
  logic       opc_jal;
  xlen_t      imm_b;
  xlen_t      imm_j;

  assign opcode = rsp.instr[6:0];

  assign opc_branch = (opcode == OPC_BRANCH);
  assign opc_jal    = (opcode == OPC_JAL);

  // ----------------------------------------------------------------------
  // immediates, bit 0 always zero
  // ----------------------------------------------------------------------
  // b-type: imm[12|10:5] in 31:25, imm[4:1|11] in 11:7
  assign imm_b = {
    {20{rsp.instr[31]}},
    rsp.instr[7],
    rsp.instr[30:25],
    rsp.instr[11:8],
    1'b0
  };

  // j-type: imm[20|10:1|11|19:12] in 31:12
  assign imm_j = {
    {12{rsp.instr[31]}},
    rsp.instr[19:12],
    rsp.instr[20],
    rsp.instr[30:21],
    1'b0
  };

  // flags only for a live response
  assign rsp.is_branch = rsp.valid & opc_branch;
  assign rsp.is_jal    = rsp.valid & opc_jal;

  // zero for every other opcode
  always_comb begin
    rsp.imm = '0;
    if (opc_branch) begin
      rsp.imm = imm_b;
    end else if (opc_jal) begin
      rsp.imm = imm_j;
    end
  end

endmodule

// File: logic/fetch_ctrl.sv
// fetch_ctrl: pc register, request and discard state, next-pc select and entry build
`timescale 1ns/1ps

module fetch_ctrl
  import fetch_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  xlen_t        boot_addr_i,
  // instruction memory request
  output logic         imem_req_valid_o,
  input  logic         imem_req_ready_i,
  output xlen_t        imem_req_addr_o,
  // instruction memory response
  input  logic         imem_rsp_valid_i,
  input  xlen_t        imem_rsp_data_i,
  input  logic         imem_rsp_err_i,
  // redirects from the back end
  input  logic         trap_i,
  input  xlen_t        trap_vector_i,
  input  logic         resolve_valid_i,
  input  logic         resolve_mispredict_i,
  input  xlen_t        resolve_target_i,
  fetch_rsp_if.ctrl    rsp,
  // queue side
  input  logic         can_accept_i,
  output logic         push_o,
  output fetch_entry_t entry_o,
  output logic         flush_o
);

  logic  rst_load_q;
  logic  outstanding_q, outstanding_d;
  logic  discard_q, discard_d;
  logic  hold_q;
  xlen_t hold_addr_q;
  xlen_t pc_q, pc_d;
  logic  mispredict;
  logic  req_fire;
  logic  rsp_accept;
  logic  pred_taken;
  xlen_t seq_pc;
  xlen_t target_pc;
  xlen_t pred_pc;

  assign mispredict = resolve_valid_i & resolve_mispredict_i;
  assign flush_o    = trap_i | mispredict;

  // ----------------------------------------------------------------------
  // request side
  // ----------------------------------------------------------------------
  // a request that was not taken stays up with its address, even across a flush
  assign imem_req_valid_o = hold_q | (~rst_load_q & ~outstanding_q & can_accept_i);
  assign imem_req_addr_o  = hold_q ? hold_addr_q : pc_q;
  assign req_fire         = imem_req_valid_o & imem_req_ready_i;

  // ----------------------------------------------------------------------
  // response side
  // ----------------------------------------------------------------------
  // pc_q still holds the address of the request in flight
  assign rsp.valid = imem_rsp_valid_i & outstanding_q & ~discard_q;
  assign rsp.pc    = pc_q;
  assign rsp.instr = imem_rsp_data_i;
  assign rsp.err   = imem_rsp_err_i;

  // a redirect in the response cycle wins over the response
  assign rsp_accept = rsp.valid & ~flush_o;

  // jal always taken, branch as the table says
  assign pred_taken = rsp.is_jal | (rsp.is_branch & rsp.pred_taken);
  assign seq_pc     = rsp.pc + INSTR_BYTES;
  assign target_pc  = rsp.pc + rsp.imm;
  assign pred_pc    = pred_taken ? target_pc : seq_pc;

  assign push_o  = rsp_accept;
  assign entry_o = '{
    pc:          rsp.pc,
    instr:       rsp.instr,
    pred_taken:  pred_taken,
    pred_target: pred_pc,
    err:         rsp.err
  };

  // next pc, later assignments take precedence
  always_comb begin : next_pc_select
    pc_d = pc_q;
    if (rst_load_q) begin
      pc_d = boot_addr_i;
    end
    if (rsp_accept) begin
      pc_d = pred_pc;
    end
    if (mispredict) begin
      pc_d = resolve_target_i;
    end
    if (trap_i) begin
      pc_d = trap_vector_i;
    end
  end

  always_comb begin : state_next
    outstanding_d = outstanding_q;
    if (req_fire) begin
      outstanding_d = 1'b1;
    end
    // response never comes in the transfer cycle
    if (imem_rsp_valid_i) begin
      outstanding_d = 1'b0;
    end
    // a discarded response clears the flag
    discard_d = discard_q & ~imem_rsp_valid_i;
    // on flush, drop whatever is in flight or about to be
    if (flush_o) begin
      discard_d = (outstanding_q & ~imem_rsp_valid_i) | imem_req_valid_o;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rst_load_q    <= 1'b1;
      pc_q          <= BOOT_ADDR_DEFAULT;
      outstanding_q <= 1'b0;
      discard_q     <= 1'b0;
      hold_q        <= 1'b0;
    end else begin
      rst_load_q    <= 1'b0;
      pc_q          <= pc_d;
      outstanding_q <= outstanding_d;
      discard_q     <= discard_d;
      hold_q        <= imem_req_valid_o & ~imem_req_ready_i;
    end
  end

  // captured every cycle, used only while hold_q is set
  always_ff @(posedge clk_i) begin
    hold_addr_q <= imem_req_addr_o;
  end

endmodule

// File: logic/fetch_frontend.sv
// fetch_frontend: top level with fetch control, branch scan, history table and fetch queue
`timescale 1ns/1ps

module fetch_frontend
  import fetch_pkg::*;
#(
  parameter int unsigned BhtEntries = 16,
  parameter int unsigned QueueDepth = 4
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  xlen_t boot_addr_i,
  // instruction memory
  output logic  imem_req_valid_o,
  input  logic  imem_req_ready_i,
  output xlen_t imem_req_addr_o,
  input  logic  imem_rsp_valid_i,
  input  xlen_t imem_rsp_data_i,
  input  logic  imem_rsp_err_i,
  // decode
  output logic  fetch_valid_o,
  input  logic  fetch_ready_i,
  output xlen_t fetch_pc_o,
  output xlen_t fetch_instr_o,
  output logic  fetch_pred_taken_o,
  output xlen_t fetch_pred_target_o,
  output logic  fetch_err_o,
  // execute
  input  logic  resolve_valid_i,
  input  xlen_t resolve_pc_i,
  input  logic  resolve_is_branch_i,
  input  logic  resolve_taken_i,
  input  logic  resolve_mispredict_i,
  input  xlen_t resolve_target_i,
  // trap
  input  logic  trap_i,
  input  xlen_t trap_vector_i
);

  fetch_rsp_if  rsp_if ();

  logic         can_accept;
  logic         push;
  logic         flush;
  fetch_entry_t push_entry;
  fetch_entry_t out_entry;

  fetch_ctrl i_fetch_ctrl (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .boot_addr_i          (boot_addr_i),
    .imem_req_valid_o     (imem_req_valid_o),
    .imem_req_ready_i     (imem_req_ready_i),
    .imem_req_addr_o      (imem_req_addr_o),
    .imem_rsp_valid_i     (imem_rsp_valid_i),
    .imem_rsp_data_i      (imem_rsp_data_i),
    .imem_rsp_err_i       (imem_rsp_err_i),
    .trap_i               (trap_i),
    .trap_vector_i        (trap_vector_i),
    .resolve_valid_i      (resolve_valid_i),
    .resolve_mispredict_i (resolve_mispredict_i),
    .resolve_target_i     (resolve_target_i),
    .rsp                  (rsp_if.ctrl),
    .can_accept_i         (can_accept),
    .push_o               (push),
    .entry_o              (push_entry),
    .flush_o              (flush)
  );

  branch_scan i_branch_scan (
    .rsp (rsp_if.scan)
  );

  // only conditional branches train the table
  branch_history_table #(
    .BhtEntries (BhtEntries)
  ) i_branch_history_table (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rsp         (rsp_if.bht),
    .upd_valid_i (resolve_valid_i & resolve_is_branch_i),
    .upd_pc_i    (resolve_pc_i),
    .upd_taken_i (resolve_taken_i)
  );

  fetch_queue #(
    .QueueDepth (QueueDepth)
  ) i_fetch_queue (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush),
    .push_i       (push),
    .entry_i      (push_entry),
    .can_accept_o (can_accept),
    .entry_o      (out_entry),
    .valid_o      (fetch_valid_o),
    .ready_i      (fetch_ready_i)
  );

  // entry fields out to decode
  assign fetch_pc_o          = out_entry.pc;
  assign fetch_instr_o       = out_entry.instr;
  assign fetch_pred_taken_o  = out_entry.pred_taken;
  assign fetch_pred_target_o = out_entry.pred_target;
  assign fetch_err_o         = out_entry.err;

endmodule

// File: logic/fetch_pkg.sv
// fetch_pkg: address and word types, fetch entry, predictor counter and opcode constants
package fetch_pkg;

  // ----------------------------------------------------------------------
  // widths and basic types
  // ----------------------------------------------------------------------
  localparam int unsigned XLEN = 32;

  // address or raw instruction word
  typedef logic [XLEN-1:0] xlen_t;

  // reset value of the pc register, overwritten by boot_addr_i one cycle later
  localparam xlen_t BOOT_ADDR_DEFAULT = 32'h8000_0000;

  // uncompressed only, so the sequential step is fixed
  localparam xlen_t INSTR_BYTES = 32'd4;

  // ----------------------------------------------------------------------
  // entry handed to decode
  // ----------------------------------------------------------------------
  typedef struct packed {
    xlen_t pc;
    xlen_t instr;
    // jal or branch predicted taken
    logic  pred_taken;
    // next pc the frontend fetched after this entry
    xlen_t pred_target;
    // bus error on the fetch of this word
    logic  err;
  } fetch_entry_t;

  // ----------------------------------------------------------------------
  // direction predictor
  // ----------------------------------------------------------------------
  typedef logic [1:0] counter_t;

  localparam counter_t CNT_STRONG_NT = 2'b00;
  localparam counter_t CNT_WEAK_NT   = 2'b01;
  localparam counter_t CNT_WEAK_T    = 2'b10;
  localparam counter_t CNT_STRONG_T  = 2'b11;

  // ----------------------------------------------------------------------
  // rv32i major opcodes seen by the scanner
  // ----------------------------------------------------------------------
  localparam logic [6:0] OPC_BRANCH = 7'b110_0011;
  localparam logic [6:0] OPC_JAL    = 7'b110_1111;

endpackage

// File: logic/fetch_queue.sv
// fetch_queue: circular buffer of fetch entries toward decode with flush and space flag
`timescale 1ns/1ps

module fetch_queue
  import fetch_pkg::*;
#(
  parameter int unsigned QueueDepth = 4
) (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         flush_i,
  // write side from fetch control
  input  logic         push_i,
  input  fetch_entry_t entry_i,
  output logic         can_accept_o,
  // read side toward decode
  output fetch_entry_t entry_o,
  output logic         valid_o,
  input  logic         ready_i
);

  localparam int unsigned PtrW = $clog2(QueueDepth);

  fetch_entry_t    mem_q [QueueDepth];
  logic [PtrW-1:0] rd_ptr_q;
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW:0]   cnt_q;
  logic            push;
  logic            pop;

  // a push in the flush cycle is dropped
  assign push = push_i & ~flush_i;
  assign pop  = valid_o & ready_i;

  assign valid_o = (cnt_q != '0);
  assign entry_o = mem_q[rd_ptr_q];

  // two free slots cover the entry of the request about to go out
  assign can_accept_o = (cnt_q <= (PtrW+1)'(QueueDepth - 2));

  // ----------------------------------------------------------------------
  // pointers and fill level
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (flush_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(QueueDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(QueueDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // push only and pop only change the level, both together keep it
      if (push && !pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (pop && !push) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= entry_i;
    end
  end

endmodule

// File: logic/fetch_rsp_if.sv
// fetch_rsp_if: scanned memory response shared by fetch control, scan, predictor and queue
`timescale 1ns/1ps

interface fetch_rsp_if
  import fetch_pkg::*;
();

  // raw response, qualified by the outstanding and discard state
  logic  valid;
  xlen_t pc;
  xlen_t instr;
  logic  err;

  // decode results of the scanner
  logic  is_branch;
  logic  is_jal;
  xlen_t imm;

  // direction from the history table or the static fallback
  logic  pred_taken;

  modport ctrl (output valid, pc, instr, err, input is_branch, is_jal, imm, pred_taken);
  modport scan (input valid, instr, output is_branch, is_jal, imm);
  modport bht (input pc, imm, output pred_taken);
  modport queue (input valid, pc, instr, err);

endinterface

// File: verification/tb_fetch_frontend.sv
// clock, reset, memory model, back end, reference predictor and entry checks
`timescale 1ns/1ps

module tb_fetch_frontend
  import fetch_pkg::*;
();

  localparam int unsigned NUM_TESTS        = 5;
  localparam int unsigned ENTRIES_PER_TEST = 300;
  // worst fetch round trip is 7 cycles plus margin for flush refill and decode stalls
  localparam int unsigned CYCLES_PER_ENTRY = 16;
  localparam int unsigned TIMEOUT_CYCLES   = 16 + NUM_TESTS * ENTRIES_PER_TEST * CYCLES_PER_ENTRY;
  localparam xlen_t       BOOT_ADDR        = 32'h0000_1000;
  localparam xlen_t       DECOY_TARGET     = 32'h0000_1f00;
  localparam logic [1:0]  K_ALU = 2'd0, K_BR = 2'd1, K_JAL = 2'd2;

  logic  clk_i, rst_ni;
  logic  imem_req_valid_o, imem_req_ready_i, imem_rsp_valid_i, imem_rsp_err_i;
  xlen_t imem_req_addr_o, imem_rsp_data_i;
  logic  fetch_valid_o, fetch_ready_i, fetch_pred_taken_o, fetch_err_o;
  xlen_t fetch_pc_o, fetch_instr_o, fetch_pred_target_o;
  logic  resolve_valid_i, resolve_is_branch_i, resolve_taken_i, resolve_mispredict_i;
  xlen_t resolve_pc_i, resolve_target_i;
  logic  trap_i;
  xlen_t trap_vector_i;

  // program image of 1024 words indexed by addr[11:2]
  logic [31:0] mem [1024];
  logic [1:0]  kind_tbl [1024];
  xlen_t       imm_tbl [1024];
  logic        taken_tbl [1024];
  logic        err_tbl [1024];

  // reference copy of the direction table
  counter_t    bht_cnt [16];
  logic        bht_vld [16];

  fetch_entry_t exp_q [$];
  xlen_t       model_pc;
  int          seed = 83716;
  int unsigned epoch, checks, errors, cycles;
  int unsigned test_entries, test_err, test_mis, test_errbits;
  // memory model state is 0 when idle, 1 with a request seen and 2 with a response pending
  int unsigned mstate, m_wait, m_epoch;
  xlen_t       m_addr;
  logic        rs_pending, rs_mis, rs_taken, squash;
  xlen_t       rs_pc, rs_target;
  logic        trap_req, trap_both, stall_mode;
  xlen_t       trap_vec;
  int unsigned stall_cnt;

  fetch_frontend #(
    .BhtEntries (16),
    .QueueDepth (4)
  ) i_fetch_frontend (.*, .boot_addr_i (BOOT_ADDR));

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // ----------------------------------------------------------------------
  // reference model and checks
  // ----------------------------------------------------------------------
  // expected entry from the program tables and the reference counters
  function automatic fetch_entry_t predict_entry(input xlen_t pc);
    fetch_entry_t e;
    int unsigned  w;
    int unsigned  b;
    w = pc[11:2];
    b = pc[5:2];
    e.pc         = pc;
    e.instr      = mem[w];
    e.err        = err_tbl[w];
    e.pred_taken = (kind_tbl[w] == K_JAL);
    if (kind_tbl[w] == K_BR) begin
      // untrained entries take backward branches and skip forward ones
      e.pred_taken = bht_vld[b] ? bht_cnt[b][1] : imm_tbl[w][31];
    end
    e.pred_target = e.pred_taken ? pc + imm_tbl[w] : pc + 32'd4;
    return e;
  endfunction

  task automatic update_model(input xlen_t pc, input logic taken);
    int unsigned b;
    b = pc[5:2];
    if (!bht_vld[b]) begin
      bht_cnt[b] = taken ? 2'b10 : 2'b01;
      bht_vld[b] = 1'b1;
    end else if (taken && bht_cnt[b] != 2'b11) begin
      bht_cnt[b] = bht_cnt[b] + 2'd1;
    end else if (!taken && bht_cnt[b] != 2'b00) begin
      bht_cnt[b] = bht_cnt[b] - 2'd1;
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      test_err++;
      $display("ERR %s got %h expected %h", name, got, exp);
    end
  endtask

  function automatic int unsigned pick_delay();
    logic [31:0] r;
    r = $random(seed);
    return r % 3;
  endfunction

  // one entry taken by decode is compared and handed to the back end
  task automatic consume_entry();
    fetch_entry_t e;
    xlen_t        actual;
    int unsigned  w;
    if (exp_q.size() == 0) begin
      errors++;
      test_err++;
      $display("decode received pc %h although no fetch was expected", fetch_pc_o);
      return;
    end
    e = exp_q.pop_front();
    check_value("fetch_pc_o", fetch_pc_o, e.pc);
    check_value("fetch_instr_o", fetch_instr_o, e.instr);
    check_value("fetch_pred_taken_o", {31'd0, fetch_pred_taken_o}, {31'd0, e.pred_taken});
    check_value("fetch_pred_target_o", fetch_pred_target_o, e.pred_target);
    check_value("fetch_err_o", {31'd0, fetch_err_o}, {31'd0, e.err});
    test_entries++;
    test_errbits += fetch_err_o;
    w = e.pc[11:2];
    // entries younger than a redirect in flight die in the back end
    if (squash || kind_tbl[w] != K_BR) begin
      return;
    end
    actual     = taken_tbl[w] ? e.pc + imm_tbl[w] : e.pc + 32'd4;
    rs_pending = 1'b1;
    rs_pc      = e.pc;
    rs_taken   = taken_tbl[w];
    rs_target  = actual;
    rs_mis     = (actual != e.pred_target);
    test_mis  += rs_mis;
  endtask

  // ----------------------------------------------------------------------
  // sampling at the rising edge sees inputs stable since the falling edge
  // ----------------------------------------------------------------------
  always @(posedge clk_i) begin
    logic flush_now;
    fetch_entry_t e;
    if (rst_ni) begin
      flush_now = trap_i | (resolve_valid_i & resolve_mispredict_i);
      if (fetch_valid_o && fetch_ready_i) begin
        consume_entry();
      end
      case (mstate)
        0: if (imem_req_valid_o) begin
          m_addr  = imem_req_addr_o;
          m_epoch = epoch;
          m_wait  = pick_delay();
          mstate  = 1;
        end
        1: begin
          // valid and address stay put until the transfer
          check_value("imem_req_valid_o", {31'd0, imem_req_valid_o}, 32'd1);
          check_value("imem_req_addr_o", imem_req_addr_o, m_addr);
          if (imem_req_valid_o && imem_req_ready_i) begin
            m_wait = pick_delay();
            mstate = 2;
          end else if (m_wait != 0) begin
            m_wait--;
          end
        end
        default: if (imem_rsp_valid_i) begin
          // requests seen before a redirect come back dropped
          if (m_epoch == epoch && !flush_now) begin
            e = predict_entry(model_pc);
            exp_q.push_back(e);
            model_pc = e.pred_target;
          end
          mstate = 0;
        end else if (m_wait != 0) begin
          m_wait--;
        end
      endcase
      if (resolve_valid_i && resolve_is_branch_i) begin
        update_model(resolve_pc_i, resolve_taken_i);
      end
      if (flush_now) begin
        exp_q.delete();
        model_pc = trap_i ? trap_vector_i : resolve_target_i;
        epoch++;
        squash = 1'b0;
      end
    end
  end

  // ----------------------------------------------------------------------
  // falling edge drives the back end, the memory model and decode ready
  // ----------------------------------------------------------------------
  always @(negedge clk_i) begin
    logic [31:0] r;
    r = $random(seed);
    resolve_valid_i      = 1'b0;
    resolve_is_branch_i  = 1'b0;
    resolve_mispredict_i = 1'b0;
    trap_i               = 1'b0;
    if (rs_pending) begin
      resolve_valid_i      = 1'b1;
      resolve_is_branch_i  = 1'b1;
      resolve_pc_i         = rs_pc;
      resolve_taken_i      = rs_taken;
      resolve_target_i     = rs_target;
      resolve_mispredict_i = rs_mis;
      squash               = squash | rs_mis;
      rs_pending           = 1'b0;
    end
    if (trap_req) begin
      trap_i        = 1'b1;
      trap_vector_i = trap_vec;
      squash        = 1'b1;
      // a mispredict in the same cycle must lose
      if (trap_both) begin
        resolve_valid_i      = 1'b1;
        resolve_mispredict_i = 1'b1;
        resolve_target_i     = DECOY_TARGET;
      end
      trap_req = 1'b0;
    end
    imem_req_ready_i = (mstate == 1 && m_wait == 0);
    imem_rsp_valid_i = (mstate == 2 && m_wait == 0);
    imem_rsp_data_i  = mem[m_addr[11:2]];
    imem_rsp_err_i   = err_tbl[m_addr[11:2]];
    if (stall_mode) begin
      if (stall_cnt != 0) begin
        fetch_ready_i = 1'b0;
        stall_cnt--;
      end else begin
        fetch_ready_i = 1'b1;
        if (r[3:0] == 4'd0) begin
          stall_cnt = 10 + r[8:4];
        end
      end
    end else begin
      fetch_ready_i = (r[1:0] != 2'd0);
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: decode stopped receiving entries after %0d cycles", cycles);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  // program image and test sequence
  // ----------------------------------------------------------------------
  task automatic load_program();
    logic [31:0] r;
    xlen_t       off;
    for (int unsigned w = 0; w < 1024; w++) begin
      r = $random(seed);
      // addi x1, x1, w keeps every alu word tied to its address
      mem[w]       = {2'b00, w[9:0], 5'd1, 3'b000, 5'd1, 7'b0010011};
      kind_tbl[w]  = K_ALU;
      imm_tbl[w]   = '0;
      taken_tbl[w] = r[4];
      err_tbl[w]   = (w >= 32) && (r[9:6] == 4'd0);
      // straight-line code at the boot address
      if (w >= 32 && (r[2:0] == 3'd4 || r[2:0] == 3'd5)) begin
        off = r[0] ? -(32'd4 + {r[12:10], 2'b00}) : 32'd8 + {r[12:10], 2'b00};
        // backward branches mostly fall through so loops end
        taken_tbl[w] = r[0] ? (r[14:13] == 2'd0) : r[4];
        kind_tbl[w]  = K_BR;
        imm_tbl[w]   = off;
        mem[w] = {off[12], off[10:5], 5'd2, 5'd1, 3'b000, off[4:1], off[11], OPC_BRANCH};
      end else if (w >= 32 && r[2:0] == 3'd6) begin
        off         = 32'd8 + {r[13:10], 2'b00};
        kind_tbl[w] = K_JAL;
        imm_tbl[w]  = off;
        mem[w]      = {off[20], off[10:1], off[11], off[19:12], 5'd0, OPC_JAL};
      end
    end
    // error word right behind the vector of the stall test
    err_tbl[10'h281] = 1'b1;
  endtask

  function automatic string test_name(input int unsigned t);
    case (t)
      1:       return "boot and sequential fetch";
      2:       return "jal and static prediction";
      3:       return "counter training";
      4:       return "trap over mispredict";
      default: return "decode stalls and error word";
    endcase
  endfunction

  initial begin : sequencer
    rst_ni = 1'b0;
    {imem_req_ready_i, imem_rsp_valid_i, imem_rsp_err_i, fetch_ready_i} = '0;
    {resolve_valid_i, resolve_is_branch_i, resolve_taken_i, resolve_mispredict_i} = '0;
    {imem_rsp_data_i, resolve_pc_i, resolve_target_i, trap_vector_i} = '0;
    trap_i = 1'b0;
    {rs_pending, rs_mis, rs_taken, squash, trap_req, trap_both, stall_mode} = '0;
    {epoch, checks, errors, cycles, mstate, m_wait, m_epoch, stall_cnt} = '0;
    m_addr   = '0;
    model_pc = BOOT_ADDR;
    for (int i = 0; i < 16; i++) begin
      bht_cnt[i] = 2'b00;
      bht_vld[i] = 1'b0;
    end
    load_program();
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    for (int unsigned t = 1; t <= NUM_TESTS; t++) begin
      {test_entries, test_err, test_mis, test_errbits} = '0;
      // test setup lands at a rising edge so the falling-edge driver picks it up cleanly
      @(posedge clk_i);
      stall_mode = (t == 5);
      if (t > 1) begin
        trap_vec  = 32'h0000_1000 + t * 32'h200;
        trap_both = (t == 4);
        trap_req  = 1'b1;
      end
      while (test_entries < ENTRIES_PER_TEST) begin
        @(negedge clk_i);
      end
      if (t == 5 && test_errbits == 0) begin
        errors++;
        test_err++;
        $display("no entry with the error bit reached decode");
      end
      $display("test %0d %s: %0d entries, %0d mispredicts, %0d error words, %0d errors",
               t, test_name(t), test_entries, test_mis, test_errbits, test_err);
    end
    $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: verilog.f
logic/fetch_pkg.sv
logic/fetch_rsp_if.sv
logic/fetch_ctrl.sv
logic/branch_scan.sv
logic/branch_history_table.sv
logic/fetch_queue.sv
logic/fetch_frontend.sv
verification/tb_fetch_frontend.sv
